// File: source/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split, tag + index + byte offset = 32 bits
`define CACHE_TAG_WIDTH     20
`define CACHE_INDEX_WIDTH   7
`define CACHE_OFFSET_WIDTH  5

// line geometry
`define CACHE_LINE_WORDS    8
`define CACHE_LINE_WIDTH    256
`define CACHE_LINE_BYTES    32
`define CACHE_SETS          128

// associativity and refill burst
`define CACHE_WAYS          2
`define CACHE_WAY_BITS      1
`define CACHE_BEATS         8

`endif

// File: source/cache_pkg.sv
`default_nettype none
`include "cache_settings.svh"

package cache_pkg;

    // byte address seen as tag / index / offset
    typedef struct packed {
        logic [`CACHE_TAG_WIDTH-1:0]    tag;
        logic [`CACHE_INDEX_WIDTH-1:0]  index;
        logic [`CACHE_OFFSET_WIDTH-1:0] offset;
    } cache_addr_fields_t;

    typedef union packed {
        logic [31:0]        word;
        cache_addr_fields_t field;
    } cache_addr_u;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH_REQ,
        REFILL
    } cache_state_e;

endpackage

`default_nettype wire

// File: source/cache_array_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

interface cache_array_if;
    import cache_pkg::*;

    // request side, from the controller
    cache_state_e                     state;
    logic                             rd_en;
    logic [`CACHE_INDEX_WIDTH-1:0]    index;
    logic [`CACHE_TAG_WIDTH-1:0]      tag;
    logic [3:0]                       wstrb;
    logic [31:0]                      wdata;
    logic [`CACHE_OFFSET_WIDTH-3:0]   word_off;
    logic                             hit_wr;
    logic                             refill_wr;
    logic [`CACHE_LINE_WIDTH-1:0]     refill_line;
    logic                             refill_dirty;
    logic [`CACHE_WAY_BITS-1:0]       repl_way;

    // lookup results, from the arrays
    logic                             hit;
    logic [`CACHE_WAY_BITS-1:0]       hit_way;
    logic                             victim_dirty;
    logic [`CACHE_TAG_WIDTH-1:0]      victim_tag;
    logic [31:0]                      rdata;

    modport ctrl (
        output state, rd_en, index, tag, wstrb, wdata, word_off,
        output hit_wr, refill_wr, refill_dirty, repl_way,
        input  hit, hit_way, victim_dirty, victim_tag, rdata
    );

    modport array (
        input  state, rd_en, index, tag, wstrb, wdata, word_off,
        input  hit_wr, refill_wr, refill_line, refill_dirty, repl_way,
        output hit, hit_way, victim_dirty, victim_tag, rdata
    );

endinterface

`default_nettype wire

// File: source/cache_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module cache_ctrl_fsm (
    input  logic               clk,
    input  logic               resetn,
    input  logic               valid,
    input  logic               op,
    input  logic [31:0]        addr,
    input  logic [3:0]         wstrb,
    input  logic [31:0]        wdata,
    output logic               addr_ok,
    output logic               data_ok,
    input  logic               rd_rdy,
    input  logic               wr_rdy,
    output logic               rd_req,
    output logic [31:0]        rd_addr,
    output logic               wr_req,
    output logic [31:0]        wr_addr,
    input  logic               line_done,
    output logic               refilling,
    cache_array_if.ctrl        arr
);
    import cache_pkg::*;

    cache_state_e                 state;
    cache_addr_u                  in_addr;
    cache_addr_u                  req_addr;
    cache_addr_u                  fetch_addr;
    cache_addr_u                  evict_addr;
    logic                         op_q;
    logic [3:0]                   wstrb_q;
    logic [31:0]                  wdata_q;
    logic [`CACHE_WAY_BITS-1:0]   repl_ptr;
    logic                         done_q;
    logic                         accept;

    assign in_addr.word = addr;
    assign addr_ok      = (state == IDLE);
    assign accept       = valid && addr_ok;

    // accepted request is held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= op;
            req_addr <= in_addr;
            wstrb_q  <= wstrb;
            wdata_q  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            repl_ptr <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (arr.hit) begin
                        state <= IDLE;
                    end else if (arr.victim_dirty) begin
                        state <= WRITEBACK;
                    end else begin
                        state <= FETCH_REQ;
                    end
                end
                WRITEBACK: begin
                    if (wr_rdy) begin
                        state <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (rd_rdy) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    // round robin moves only on refill
                    if (line_done) begin
                        state    <= IDLE;
                        repl_ptr <= repl_ptr + 1'b1;
                        done_q   <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a hit answers in LOOKUP and a miss the cycle after the last beat
    assign data_ok   = ((state == LOOKUP) && arr.hit) || done_q;
    assign refilling = (state == REFILL);
    assign wr_req    = (state == WRITEBACK);
    assign rd_req    = (state == FETCH_REQ);

    // line-aligned memory addresses
    assign fetch_addr.field = '{tag: req_addr.field.tag, index: req_addr.field.index, offset: '0};
    assign evict_addr.field = '{tag: arr.victim_tag, index: req_addr.field.index, offset: '0};
    assign rd_addr = fetch_addr.word;
    assign wr_addr = evict_addr.word;

    // arrays are read at the accept edge, so index bypasses the register in IDLE
    assign arr.state        = state;
    assign arr.rd_en        = accept;
    assign arr.index        = (state == IDLE) ? in_addr.field.index : req_addr.field.index;
    assign arr.tag          = req_addr.field.tag;
    assign arr.word_off     = req_addr.field.offset[`CACHE_OFFSET_WIDTH-1:2];
    assign arr.wstrb        = op_q ? wstrb_q : 4'b0000;
    assign arr.wdata        = wdata_q;
    assign arr.hit_wr       = (state == LOOKUP) && arr.hit && op_q;
    assign arr.refill_wr    = (state == REFILL) && line_done;
    assign arr.refill_dirty = op_q;
    assign arr.repl_way     = repl_ptr;

    // the refilled way must already read back as a hit in the done cycle
    a_refill_hit : assert property (@(posedge clk) disable iff (!resetn)
        done_q |-> arr.hit);

endmodule

`default_nettype wire

// File: source/refill_counter.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module refill_counter (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         refilling,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    output logic                         line_done,
    output logic [`CACHE_LINE_WIDTH-1:0] line
);

    logic [$clog2(`CACHE_BEATS)-1:0] beat_cnt;
    logic [`CACHE_LINE_WIDTH-1:0]    line_q;
    logic                            beat;

    assign beat      = refilling && ret_valid;
    assign line_done = beat && (beat_cnt == `CACHE_BEATS - 1);

    // wraps back to zero after the last beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            line_q <= line;
        end
    end

    // current beat folded in so the full line is ready on the last edge
    always_comb begin
        line = line_q;
        if (beat) begin
            line[beat_cnt*(`CACHE_LINE_WIDTH/`CACHE_LINE_WORDS) +:
                 (`CACHE_LINE_WIDTH/`CACHE_LINE_WORDS)] = ret_data;
        end
    end

    a_last_beat : assert property (@(posedge clk) disable iff (!resetn)
        beat |-> (ret_last == (beat_cnt == `CACHE_BEATS - 1)));

endmodule

`default_nettype wire

// File: source/cache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module cache_tag_array (
    input  logic         clk,
    input  logic         resetn,
    cache_array_if.array arr
);
    import cache_pkg::*;

    logic [`CACHE_TAG_WIDTH-1:0] tags [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0]      valid_bits [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0]      dirty_bits [`CACHE_WAYS];
    logic [`CACHE_TAG_WIDTH-1:0] tag_q [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]      valid_q;
    logic [`CACHE_WAYS-1:0]      dirty_q;
    logic [`CACHE_WAYS-1:0]      hit_vec;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_bits[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            if (arr.rd_en) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid_q[w] <= valid_bits[w][arr.index];
                end
            end else if (arr.refill_wr) begin
                valid_q[arr.repl_way] <= 1'b1;
            end
            if (arr.refill_wr) begin
                valid_bits[arr.repl_way][arr.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.refill_wr) begin
            tags[arr.repl_way][arr.index]       <= arr.tag;
            dirty_bits[arr.repl_way][arr.index] <= arr.refill_dirty;
        end else if (arr.hit_wr) begin
            dirty_bits[arr.hit_way][arr.index] <= 1'b1;
        end
    end

    // read registers also take the refilled way, so the done cycle sees a hit
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                tag_q[w]   <= tags[w][arr.index];
                dirty_q[w] <= dirty_bits[w][arr.index];
            end
        end else if (arr.refill_wr) begin
            tag_q[arr.repl_way]   <= arr.tag;
            dirty_q[arr.repl_way] <= arr.refill_dirty;
        end
    end

    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = valid_q[w] && (tag_q[w] == arr.tag);
            if (hit_vec[w]) begin
                arr.hit_way = `CACHE_WAY_BITS'(w);
            end
        end
    end

    assign arr.hit          = |hit_vec;
    assign arr.victim_dirty = valid_q[arr.repl_way] && dirty_q[arr.repl_way];
    assign arr.victim_tag   = tag_q[arr.repl_way];

    a_single_hit : assert property (@(posedge clk) disable iff (!resetn)
        (arr.state == LOOKUP) |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// File: source/cache_data_array.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module cache_data_array (
    input  logic                         clk,
    output logic [`CACHE_LINE_WIDTH-1:0] wr_data,
    cache_array_if.array                 arr
);

    logic [`CACHE_LINE_WIDTH-1:0] lines [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_LINE_WIDTH-1:0] line_q [`CACHE_WAYS];
    logic [`CACHE_LINE_WIDTH-1:0] base_line;
    logic [`CACHE_LINE_WIDTH-1:0] merged_line;
    logic [`CACHE_WAY_BITS-1:0]   wr_way;
    logic                         wr_en;

    assign wr_en     = arr.hit_wr || arr.refill_wr;
    assign wr_way    = arr.refill_wr ? arr.repl_way : arr.hit_way;
    assign base_line = arr.refill_wr ? arr.refill_line : line_q[arr.hit_way];

    // strobed bytes of the addressed word replace the old ones
    always_comb begin
        merged_line = base_line;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if ((b / 4 == arr.word_off) && arr.wstrb[b % 4]) begin
                merged_line[b*8 +: 8] = arr.wdata[(b % 4)*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines[wr_way][arr.index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                line_q[w] <= lines[w][arr.index];
            end
        end else if (arr.refill_wr) begin
            line_q[arr.repl_way] <= merged_line;
        end
    end

    assign arr.rdata = line_q[arr.hit_way][arr.word_off*32 +: 32];

    // victim line for the write-back
    assign wr_data = line_q[arr.repl_way];

endmodule

`default_nettype wire

// File: source/cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module cache (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         valid,
    input  logic                         op,
    input  logic [31:0]                  addr,
    input  logic [3:0]                   wstrb,
    input  logic [31:0]                  wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [31:0]                  rdata,
    output logic                         rd_req,
    output logic [31:0]                  rd_addr,
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [31:0]                  ret_data,
    output logic                         wr_req,
    output logic [31:0]                  wr_addr,
    output logic [`CACHE_LINE_WIDTH-1:0] wr_data,
    input  logic                         wr_rdy
);

    logic line_done;
    logic refilling;

    cache_array_if arr_if ();

    cache_ctrl_fsm u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rd_rdy    (rd_rdy),
        .wr_rdy    (wr_rdy),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .line_done (line_done),
        .refilling (refilling),
        .arr       (arr_if.ctrl)
    );

    // assembled line goes straight onto the array bus
    refill_counter u_refill (
        .clk       (clk),
        .resetn    (resetn),
        .refilling (refilling),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .line_done (line_done),
        .line      (arr_if.refill_line)
    );

    cache_tag_array u_tags (
        .clk    (clk),
        .resetn (resetn),
        .arr    (arr_if.array)
    );

    cache_data_array u_data (
        .clk     (clk),
        .wr_data (wr_data),
        .arr     (arr_if.array)
    );

    assign rdata = arr_if.rdata;

endmodule

`default_nettype wire

// File: verif/tb_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_settings.svh"

module tb_cache;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    logic                         clk;
    logic                         resetn;
    logic                         valid;
    logic                         op;
    logic [31:0]                  addr;
    logic [3:0]                   wstrb;
    logic [31:0]                  wdata;
    logic                         addr_ok;
    logic                         data_ok;
    logic [31:0]                  rdata;
    logic                         rd_req;
    logic [31:0]                  rd_addr;
    logic                         rd_rdy    = 1'b0;
    logic                         ret_valid = 1'b0;
    logic                         ret_last  = 1'b0;
    logic [31:0]                  ret_data  = '0;
    logic                         wr_req;
    logic [31:0]                  wr_addr;
    logic [`CACHE_LINE_WIDTH-1:0] wr_data;
    logic                         wr_rdy    = 1'b0;

    // backing memory and the expected cpu view are sparse by byte address
    logic [31:0] mem [logic [31:0]];
    logic [31:0] ref_mem [logic [31:0]];

    logic [31:0]                  stall_seed = 32'd99;
    logic [31:0]                  stim_seed  = 32'd99;
    logic                         stall_on   = 1'b0;
    logic                         filling    = 1'b0;
    logic [31:0]                  fill_base  = '0;
    int                           fill_cnt   = 0;
    int                           rd_count   = 0;
    int                           wb_count   = 0;
    int                           errors     = 0;
    logic [31:0]                  last_rd_addr;
    logic [31:0]                  last_wb_addr;
    logic [`CACHE_LINE_WIDTH-1:0] last_wb_data;

    cache u_cache (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // power-up contents hash the full address
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : init_word(a);
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic void ref_write(input logic [31:0] a, input logic [3:0] strb,
                                      input logic [31:0] data);
        ref_mem[a] = merge_word(ref_word(a), data, strb);
    endfunction

    function automatic logic [`CACHE_LINE_WIDTH-1:0] ref_line(input logic [31:0] base);
        logic [`CACHE_LINE_WIDTH-1:0] line;
        for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
            line[k*32 +: 32] = ref_word(base + 4 * k);
        end
        return line;
    endfunction

    task automatic expect_equal(input string name, input logic [`CACHE_LINE_WIDTH-1:0] got,
                                input logic [`CACHE_LINE_WIDTH-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // memory side takes write-backs and returns eight-beat refills with optional stalls
    always @(posedge clk) begin : memory_model
        logic [31:0] bits;
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            filling   = 1'b0;
        end else begin
            if (wr_req && wr_rdy) begin
                for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
                    mem[wr_addr + 4 * k] = wr_data[k*32 +: 32];
                end
                last_wb_addr <= wr_addr;
                last_wb_data <= wr_data;
                wb_count     <= wb_count + 1;
            end
            if (rd_req && rd_rdy) begin
                fill_base    = rd_addr;
                fill_cnt     = 0;
                filling      = 1'b1;
                last_rd_addr <= rd_addr;
                rd_count     <= rd_count + 1;
            end
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (filling) begin
                take_bits(stall_seed, 1, bits);
                if (!stall_on || bits[0]) begin
                    ret_valid <= 1'b1;
                    ret_last  <= (fill_cnt == `CACHE_BEATS - 1);
                    ret_data  <= mem_word(fill_base + 4 * fill_cnt);
                    fill_cnt  = fill_cnt + 1;
                    filling   = (fill_cnt < `CACHE_BEATS);
                end
            end
            take_bits(stall_seed, 1, bits);
            wr_rdy <= !stall_on || bits[0];
            take_bits(stall_seed, 1, bits);
            rd_rdy <= !stall_on || bits[0];
        end
    end

    // latency counts edges from acceptance to the data_ok edge
    task automatic cpu_access(input logic is_write, input logic [31:0] a,
                              input logic [3:0] strb, input logic [31:0] data,
                              output logic [31:0] word, output int latency);
        latency = 0;
        valid   <= 1'b1;
        op      <= is_write;
        addr    <= a;
        wstrb   <= strb;
        wdata   <= data;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        valid <= 1'b0;
        do begin
            @(posedge clk);
            latency++;
        end while (!data_ok);
        word = rdata;
    endtask

    task automatic check_reset_state();
        @(posedge clk);
        expect_equal("addr_ok", addr_ok, 1'b1);
        expect_equal("data_ok", data_ok, 1'b0);
        expect_equal("rd_req", rd_req, 1'b0);
        expect_equal("wr_req", wr_req, 1'b0);
    endtask

    task automatic read_miss_then_hit();
        logic [31:0] a;
        logic [31:0] got;
        int          lat;
        int          rd0;
        a   = 32'h0001_2348;
        rd0 = rd_count;
        cpu_access(1'b0, a, 4'b0000, 32'h0, got, lat);
        expect_equal("rd_addr", last_rd_addr, a & 32'hFFFF_FFE0);
        expect_equal("rdata", got, ref_word(a));
        expect_equal("refill count", rd_count, rd0 + 1);
        cpu_access(1'b0, a + 4, 4'b0000, 32'h0, got, lat);
        expect_equal("rdata", got, ref_word(a + 4));
        expect_equal("read hit latency", lat, 1);
        expect_equal("refill count", rd_count, rd0 + 1);
    endtask

    task automatic merge_partial_writes();
        logic [31:0] a;
        logic [31:0] got;
        int          lat;
        int          rd0;
        a   = 32'h0001_2350;
        rd0 = rd_count;
        cpu_access(1'b1, a, 4'b0101, 32'hA1B2_C3D4, got, lat);
        ref_write(a, 4'b0101, 32'hA1B2_C3D4);
        expect_equal("write hit latency", lat, 1);
        cpu_access(1'b1, a, 4'b1000, 32'h5566_7788, got, lat);
        ref_write(a, 4'b1000, 32'h5566_7788);
        cpu_access(1'b0, a, 4'b0000, 32'h0, got, lat);
        expect_equal("rdata", got, ref_word(a));
        expect_equal("read hit latency", lat, 1);
        expect_equal("refill count", rd_count, rd0);
    endtask

    task automatic evict_dirty_line();
        logic [31:0] line1;
        logic [31:0] line2;
        logic [31:0] line3;
        logic [31:0] got;
        int          lat;
        int          wb0;
        int          rd0;
        line1 = 32'h0010_0200;
        line2 = 32'h0020_0200;
        line3 = 32'h0030_0200;
        // odd refill count means the pointer sits on way 1
        if (rd_count % 2 != 0) begin
            cpu_access(1'b0, 32'h0000_0F00, 4'b0000, 32'h0, got, lat);
        end
        cpu_access(1'b0, line1, 4'b0000, 32'h0, got, lat);
        expect_equal("rdata", got, ref_word(line1));
        cpu_access(1'b1, line1 + 12, 4'b0011, 32'hCAFE_F00D, got, lat);
        ref_write(line1 + 12, 4'b0011, 32'hCAFE_F00D);
        expect_equal("write hit latency", lat, 1);
        wb0 = wb_count;
        cpu_access(1'b0, line2, 4'b0000, 32'h0, got, lat);
        expect_equal("write-back count", wb_count, wb0);
        cpu_access(1'b0, line3, 4'b0000, 32'h0, got, lat);
        expect_equal("rdata", got, ref_word(line3));
        expect_equal("write-back count", wb_count, wb0 + 1);
        expect_equal("wr_addr", last_wb_addr, line1);
        expect_equal("wr_data", last_wb_data, ref_line(line1));
        rd0 = rd_count;
        cpu_access(1'b0, line1 + 12, 4'b0000, 32'h0, got, lat);
        expect_equal("rdata", got, ref_word(line1 + 12));
        expect_equal("refill count", rd_count, rd0 + 1);
        expect_equal("memory word", mem_word(line1 + 12), ref_word(line1 + 12));
    endtask

    // four tags over two sets, so misses keep evicting
    task automatic random_traffic();
        logic [31:0] bits;
        logic        is_write;
        logic [1:0]  tag_sel;
        logic        set_sel;
        logic [2:0]  word_sel;
        logic [3:0]  strb;
        logic [31:0] data;
        logic [31:0] a;
        logic [31:0] got;
        int          lat;
        stall_on <= 1'b1;
        for (int n = 0; n < 48; n++) begin
            take_bits(stim_seed, 1, bits);
            is_write = bits[0];
            take_bits(stim_seed, 2, bits);
            tag_sel = bits[1:0];
            take_bits(stim_seed, 1, bits);
            set_sel = bits[0];
            take_bits(stim_seed, 3, bits);
            word_sel = bits[2:0];
            take_bits(stim_seed, 4, bits);
            strb = bits[3:0];
            take_bits(stim_seed, 32, data);
            a = {18'h00040, tag_sel, 6'h08, set_sel, word_sel, 2'b00};
            if (is_write) begin
                cpu_access(1'b1, a, strb, data, got, lat);
                ref_write(a, strb, data);
            end else begin
                cpu_access(1'b0, a, 4'b0000, 32'h0, got, lat);
                expect_equal("rdata", got, ref_word(a));
            end
        end
        stall_on <= 1'b0;
    endtask

    initial begin
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        addr   = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        check_reset_state();
        read_miss_then_hit();
        merge_partial_writes();
        evict_dirty_line();
        random_traffic();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: cache.f
+incdir+source
source/cache_pkg.sv
source/cache_array_if.sv
source/cache_ctrl_fsm.sv
source/refill_counter.sv
source/cache_tag_array.sv
source/cache_data_array.sv
source/cache.sv
verif/tb_cache.sv

// File: Makefile
# Verilator flow for the cache testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
